//--- bench/tb_mempool_l2_system.sv
/*
 * Testbench for the L2 memory system. Drives both initiator ports and checks
 * every response against a model of the L2, the boot ROM and the control block.
 */
`timescale 1ns/1ns

module tb_mempool_l2_system
  import mempool_l2_pkg::*;
();

  localparam int unsigned NumOps     = 16;
  // Expected cycles of each test in run order plus reset
  localparam int unsigned TestCycles = 10 + 70 + 20 + 20 + 10 + 20 + 10;
  localparam int unsigned MaxCycles  = 4 * TestCycles;

  logic                         clk;
  logic                         reset;
  logic     [NumInitiators-1:0] req;
  mem_req_t [NumInitiators-1:0] mem_req;
  logic     [NumInitiators-1:0] gnt;
  logic     [NumInitiators-1:0] rvalid;
  data_t    [NumInitiators-1:0] rdata;
  logic     [NumCores-1:0]      wake_up;
  data_t                        eoc;
  logic                         eoc_valid;

  // Reference model state
  data_t               l2_model [NumL2Banks*L2BankNumWords];
  logic [NumCores-1:0] wake_model;
  data_t               eoc_model;
  ini_idx_t            prio_model [NumTargets];
  logic [NumInitiators-1:0] exp_valid;
  logic [NumInitiators-1:0] exp_read;
  data_t               exp_data [NumInitiators];

  addr_t       l2_addrs [NumInitiators][NumOps];
  data_t       l2_wdata [NumInitiators][NumOps];
  int unsigned errors       = 0;
  int unsigned cycles       = 0;
  int unsigned rvalid_count = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  mempool_l2_system u_mempool_l2_system (
    .clk_i       (clk      ),
    .reset_i     (reset    ),
    .req_i       (req      ),
    .mem_req_i   (mem_req  ),
    .gnt_o       (gnt      ),
    .rvalid_o    (rvalid   ),
    .rdata_o     (rdata    ),
    .wake_up_o   (wake_up  ),
    .eoc_o       (eoc      ),
    .eoc_valid_o (eoc_valid)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MaxCycles) begin
      $display("Timeout: run did not end within %0d cycles", MaxCycles);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("Fail at %0t ns: %s", $time, msg);
  endtask

  // Region rules of the address map
  function automatic int unsigned target_of(input addr_t addr);
    if (addr >= L2BaseAddr && addr < L2BaseAddr + L2Size) begin
      return 32'(addr[3:2]);
    end else if (addr >= BootromBaseAddr && addr < BootromBaseAddr + 4 * BootromNumWords) begin
      return TgtBootrom;
    end
    return TgtCtrl;
  endfunction

  // Returns the expected read data and applies any write to the model
  function automatic data_t predict(input mem_req_t r);
    int unsigned idx;
    addr_t       ofs;
    data_t       rd;
    rd = '0;
    case (target_of(r.addr))
      TgtBootrom: begin
        idx = (r.addr - BootromBaseAddr) >> 2;
        rd  = bootrom_image[idx];
      end
      TgtCtrl: begin
        ofs = r.addr - CtrlBaseAddr;
        if (ofs[9:2] == 8'd0) begin
          rd = data_t'(wake_model);
          if (r.we) wake_model = r.wdata[NumCores-1:0];
        end else if (ofs[9:2] == 8'd1) begin
          rd = eoc_model;
          if (r.we) eoc_model = r.wdata;
        end
      end
      default: begin
        idx = (r.addr - L2BaseAddr) >> 2;
        rd  = l2_model[idx];
        for (int j = 0; j < StrbWidth; j++) begin
          if (r.we && r.strb[j]) l2_model[idx][8*j +: 8] = r.wdata[8*j +: 8];
        end
      end
    endcase
    return rd;
  endfunction

  // One response exactly one cycle after each acceptance
  for (genvar i = 0; i < NumInitiators; i++) begin : gen_handshake_checks
    assert property (@(posedge clk) disable iff (reset) req[i] && gnt[i] |=> rvalid[i])
      else flag_error($sformatf("port %0d accepted a request but gave no rvalid", i));
    assert property (@(posedge clk) disable iff (reset) rvalid[i] |-> $past(req[i] && gnt[i]))
      else flag_error($sformatf("port %0d gave rvalid without an accepted request", i));
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    int unsigned tgt [NumInitiators];
    ini_idx_t    win;
    if (reset) begin
      exp_valid  = '0;
      wake_model = '0;
      eoc_model  = '0;
      for (int t = 0; t < NumTargets; t++) prio_model[t] = '0;
    end else begin
      for (int i = 0; i < NumInitiators; i++) begin
        assert (rvalid[i] == exp_valid[i])
          else flag_error($sformatf("port %0d rvalid %0b, expected %0b", i, rvalid[i],
                                    exp_valid[i]));
        if (exp_valid[i] && exp_read[i]) begin
          assert (rdata[i] == exp_data[i])
            else flag_error($sformatf("port %0d rdata %h, expected %h", i, rdata[i],
                                      exp_data[i]));
        end
        tgt[i] = target_of(mem_req[i].addr);
      end
      if (rvalid[1]) rvalid_count++;
      if (req[0] && req[1] && tgt[0] == tgt[1]) begin
        win = prio_model[tgt[0]];
        assert (gnt[win] && !gnt[~win])
          else flag_error($sformatf("conflict on target %0d granted %b", tgt[0], gnt));
        prio_model[tgt[0]] = ~win;
      end else begin
        assert (gnt == req) else flag_error($sformatf("grants %b for requests %b", gnt, req));
      end
      for (int i = 0; i < NumInitiators; i++) begin
        exp_valid[i] = req[i] && gnt[i];
        exp_read[i]  = !mem_req[i].we;
        if (exp_valid[i]) exp_data[i] = predict(mem_req[i]);
      end
    end
  end

  // Holds the request until the falling edge shows a grant
  task automatic issue(input int unsigned ini, input addr_t addr, input logic we,
                       input data_t wdata, input strb_t strb);
    logic granted;
    granted      = 1'b0;
    req[ini]     = 1'b1;
    mem_req[ini] = '{addr: addr, we: we, wdata: wdata, strb: strb};
    while (!granted) begin
      @(negedge clk);
      granted = gnt[ini];
      @(posedge clk);
      #2;
    end
    req[ini] = 1'b0;
  endtask

  task automatic l2_traffic(input int unsigned ini);
    for (int k = 0; k < NumOps; k++) issue(ini, l2_addrs[ini][k], 1'b1, l2_wdata[ini][k], '1);
    for (int k = 0; k < NumOps; k++) issue(ini, l2_addrs[ini][k], 1'b0, '0, '0);
  endtask

  task automatic drain();
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic end_test(input string name, input int unsigned errs_before);
    if (errors == errs_before) begin
      $display("Test %s: ok", name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin : stimulus
    int unsigned mark;
    int unsigned start;
    addr_t       a0;
    addr_t       a1;
    void'($urandom(32'h94fb));
    reset   = 1'b1;
    req     = '0;
    mem_req = '0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    assert (wake_up == '0 && eoc == '0 && !eoc_valid)
      else flag_error("control outputs not cleared by reset");

    mark = errors;
    for (int i = 0; i < NumInitiators; i++) begin
      for (int k = 0; k < NumOps; k++) begin
        // Initiators own separate word ranges and k walks through the banks
        l2_addrs[i][k] = L2BaseAddr + (((i * 128 + $urandom % 128) * NumL2Banks + k % 4) << 2);
        l2_wdata[i][k] = $urandom;
      end
    end
    fork
      l2_traffic(0);
      l2_traffic(1);
    join
    drain();
    end_test("l2_write_read", mark);

    mark = errors;
    for (int k = 0; k < 8; k++) issue(k % 2, l2_addrs[0][k], 1'b1, $urandom, strb_t'($urandom));
    for (int k = 0; k < 8; k++) issue(k % 2, l2_addrs[0][k], 1'b0, '0, '0);
    drain();
    end_test("byte_strobes", mark);

    mark = errors;
    for (int k = 0; k < BootromNumWords; k++) begin
      issue(k % 2, BootromBaseAddr + 4 * k, 1'b0, '0, '0);
    end
    issue(1, BootromBaseAddr + 12, 1'b1, 32'hdead_beef, '1);
    issue(0, BootromBaseAddr + 12, 1'b0, '0, '0);
    drain();
    end_test("bootrom", mark);

    mark = errors;
    issue(0, CtrlBaseAddr, 1'b1, 32'hffff_fffa, '1);
    assert (wake_up == 4'ha) else flag_error("wake_up_o not set by its write");
    issue(1, CtrlBaseAddr + 4, 1'b1, 32'h1234_5679, '1);
    assert (eoc == 32'h1234_5679 && eoc_valid) else flag_error("eoc_o or eoc_valid_o wrong");
    issue(1, CtrlBaseAddr + 4, 1'b1, 32'h0000_0008, '1);
    assert (eoc == 32'h0000_0008 && !eoc_valid) else flag_error("eoc_valid_o not cleared");
    issue(0, CtrlBaseAddr, 1'b0, '0, '0);
    issue(0, CtrlBaseAddr + 4, 1'b0, '0, '0);
    issue(1, 32'h2000_0020, 1'b0, '0, '0);
    drain();
    end_test("ctrl_registers", mark);

    mark  = errors;
    start = cycles;
    // Both ports write bank 2 and then each reads what the other wrote
    fork
      for (int k = 0; k < 4; k++) issue(0, L2BaseAddr + (((200 + k) * 4 + 2) << 2), 1'b1,
                                        $urandom, '1);
      for (int k = 0; k < 4; k++) issue(1, L2BaseAddr + (((220 + k) * 4 + 2) << 2), 1'b1,
                                        $urandom, '1);
    join
    // One bank takes exactly one request per cycle
    assert (cycles - start == 8)
      else flag_error("bank 2 did not accept one request per cycle under conflict");
    fork
      for (int k = 0; k < 4; k++) issue(0, L2BaseAddr + (((220 + k) * 4 + 2) << 2), 1'b0,
                                        '0, '0);
      for (int k = 0; k < 4; k++) issue(1, L2BaseAddr + (((200 + k) * 4 + 2) << 2), 1'b0,
                                        '0, '0);
    join
    drain();
    end_test("round_robin", mark);

    mark         = errors;
    rvalid_count = 0;
    start        = cycles;
    for (int k = 0; k < 8; k++) issue(1, l2_addrs[1][k], 1'b0, '0, '0);
    assert (cycles - start == 8)
      else flag_error("back-to-back reads were not accepted each cycle");
    drain();
    assert (rvalid_count == 8)
      else flag_error($sformatf("%0d responses for 8 reads", rvalid_count));
    end_test("back_to_back", mark);

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
             tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_mempool_l2_system

//--- build.f
source/mempool_l2_pkg.sv
source/l2_region_decode.sv
source/l2_bank_xbar.sv
source/l2_bank_array.sv
source/bootrom.sv
source/ctrl_registers.sv
source/l2_resp_route.sv
source/mempool_l2_system.sv
bench/tb_mempool_l2_system.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by its printed result
verilator --binary --assert -Wno-fatal --top-module tb_mempool_l2_system -f build.f \
  && ./obj_dir/Vtb_mempool_l2_system | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }

//--- source/bootrom.sv
/*
 * Read-only boot image with a registered read port.
 * Has no write path, so writes addressed here are dropped.
 */
`timescale 1ns/1ns

module bootrom
  import mempool_l2_pkg::*;
(
  input  logic       clk_i,
  input  logic       req_i,
  input  word_addr_t addr_i,
  output data_t      rdata_o
);

  logic [BootromIdxWidth-1:0] word_idx;

  // Decode already limits the index to the image size
  assign word_idx = addr_i[BootromIdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= bootrom_image[word_idx];
    end
  end

endmodule : bootrom

//--- source/ctrl_registers.sv
/*
 * Wake-up and end-of-computation registers of the system.
 * Word 0 holds the wake-up vector, word 1 the eoc value; others read zero.
 */
`timescale 1ns/1ns

module ctrl_registers
  import mempool_l2_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  tgt_req_t            req_i,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output data_t               eoc_o,
  output logic                eoc_valid_o
);

  // Full-word writes only
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_up_o   <= '0;
      eoc_o       <= '0;
      eoc_valid_o <= 1'b0;
    end else if (valid_i && req_i.we) begin
      if (req_i.addr == CtrlWakeUpWord) begin
        wake_up_o <= req_i.wdata[NumCores-1:0];
      end else if (req_i.addr == CtrlEocWord) begin
        eoc_o       <= req_i.wdata;
        eoc_valid_o <= req_i.wdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !req_i.we) begin
      case (req_i.addr)
        CtrlWakeUpWord: rdata_o <= data_t'(wake_up_o);
        CtrlEocWord:    rdata_o <= eoc_o;
        default:        rdata_o <= '0;
      endcase
    end
  end

endmodule : ctrl_registers

//--- source/l2_bank_array.sv
/*
 * Word-interleaved L2 scratchpad, one single-port SRAM per bank.
 * Byte-enabled writes and a registered read port.
 */
`timescale 1ns/1ns

module l2_bank_array
  import mempool_l2_pkg::*;
(
  input  logic                      clk_i,
  input  logic     [NumL2Banks-1:0] bank_valid_i,
  input  tgt_req_t [NumL2Banks-1:0] bank_req_i,
  output data_t    [NumL2Banks-1:0] bank_rdata_o
);

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_bank
    data_t mem [L2BankNumWords];
    data_t rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_valid_i[b]) begin
        if (bank_req_i[b].we) begin
          for (int unsigned j = 0; j < StrbWidth; j++) begin
            if (bank_req_i[b].strb[j]) begin
              mem[bank_req_i[b].addr][8*j +: 8] <= bank_req_i[b].wdata[8*j +: 8];
            end
          end
        end
        // Read returns the old word on a write
        rdata_q <= mem[bank_req_i[b].addr];
      end
    end

    assign bank_rdata_o[b] = rdata_q;
  end

endmodule : l2_bank_array

//--- source/l2_bank_xbar.sv
/*
 * Request crossbar with one round-robin arbiter per target.
 * Grants go back to the initiators in the same cycle; the winner is forwarded.
 */
`timescale 1ns/1ns

module l2_bank_xbar
  import mempool_l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic     [NumInitiators-1:0] req_i,
  input  tgt_idx_t [NumInitiators-1:0] tgt_idx_i,
  input  tgt_req_t [NumInitiators-1:0] tgt_req_i,
  output logic     [NumInitiators-1:0] gnt_o,
  output logic     [NumTargets-1:0]    tgt_valid_o,
  output tgt_req_t [NumTargets-1:0]    tgt_req_o,
  output ini_idx_t [NumTargets-1:0]    tgt_ini_o
);

  // Initiator favoured by each target on the next conflict
  ini_idx_t [NumTargets-1:0] prio_q, prio_d;

  always_comb begin
    logic [NumInitiators-1:0] match;
    ini_idx_t                 winner;
    logic                     found;
    int unsigned              cand;

    gnt_o  = '0;
    prio_d = prio_q;
    for (int unsigned t = 0; t < NumTargets; t++) begin
      for (int unsigned i = 0; i < NumInitiators; i++) begin
        match[i] = req_i[i] && (tgt_idx_i[i] == tgt_idx_t'(t));
      end

      // Search starts at the pointer and wraps around
      winner = prio_q[t];
      found  = 1'b0;
      for (int unsigned k = 0; k < NumInitiators; k++) begin
        cand = (int'(prio_q[t]) + k) % NumInitiators;
        if (!found && match[cand]) begin
          winner = ini_idx_t'(cand);
          found  = 1'b1;
        end
      end

      tgt_valid_o[t] = found;
      tgt_ini_o[t]   = winner;
      tgt_req_o[t]   = tgt_req_i[winner];
      if (found) begin
        gnt_o[winner] = 1'b1;
      end

      // Pointer only moves on a real conflict
      if ($countones(match) > 1) begin
        prio_d[t] = ini_idx_t'((int'(winner) + 1) % NumInitiators);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= '0;
    end else begin
      prio_q <= prio_d;
    end
  end

endmodule : l2_bank_xbar

//--- source/l2_region_decode.sv
/*
 * Maps each initiator address to a target index and a local word address.
 * Purely combinational, sits in front of the crossbar.
 */
`timescale 1ns/1ns

module l2_region_decode
  import mempool_l2_pkg::*;
(
  input  logic     [NumInitiators-1:0] req_i,
  input  mem_req_t [NumInitiators-1:0] mem_req_i,
  output tgt_idx_t [NumInitiators-1:0] tgt_idx_o,
  output tgt_req_t [NumInitiators-1:0] tgt_req_o
);

  for (genvar i = 0; i < NumInitiators; i++) begin : gen_decode
    l2_addr_u   addr;
    addr_t      ctrl_offset;
    tgt_idx_t   idx;
    word_addr_t local_addr;

    assign addr        = mem_req_i[i].addr;
    assign ctrl_offset = addr.raw - CtrlBaseAddr;

    always_comb begin
      if (addr.raw >= L2BaseAddr && addr.raw < L2EndAddr) begin
        // Interleaved banks, consecutive words hit consecutive banks
        idx        = tgt_idx_t'(addr.l2.bank);
        local_addr = addr.l2.word;
      end else if (addr.raw >= BootromBaseAddr && addr.raw < BootromEndAddr) begin
        idx        = tgt_idx_t'(TgtBootrom);
        local_addr = word_addr_t'(addr.raw[ByteOffWidth +: BootromIdxWidth]);
      end else begin
        // Control block doubles as the default target
        idx        = tgt_idx_t'(TgtCtrl);
        local_addr = ctrl_offset[ByteOffWidth +: BankWordWidth];
      end
    end

    assign tgt_idx_o[i] = idx;
    // Idle ports never present a write
    assign tgt_req_o[i] = '{
      addr:  local_addr,
      we:    mem_req_i[i].we & req_i[i],
      wdata: mem_req_i[i].wdata,
      strb:  mem_req_i[i].strb
    };
  end

endmodule : l2_region_decode

//--- source/l2_resp_route.sv
/*
 * Response path, registers each target strobe and its winning initiator.
 * One cycle later the target's read data is steered to that initiator.
 */
`timescale 1ns/1ns

module l2_resp_route
  import mempool_l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic     [NumTargets-1:0]    tgt_valid_i,
  input  ini_idx_t [NumTargets-1:0]    tgt_ini_i,
  input  data_t    [NumTargets-1:0]    tgt_rdata_i,
  output logic     [NumInitiators-1:0] rvalid_o,
  output data_t    [NumInitiators-1:0] rdata_o
);

  logic     [NumTargets-1:0] valid_q;
  ini_idx_t [NumTargets-1:0] ini_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= tgt_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ini_q <= tgt_ini_i;
  end

  // An initiator owns at most one target per cycle, so no collisions
  always_comb begin
    rvalid_o = '0;
    rdata_o  = '0;
    for (int unsigned t = 0; t < NumTargets; t++) begin
      if (valid_q[t]) begin
        rvalid_o[ini_q[t]] = 1'b1;
        rdata_o[ini_q[t]]  = tgt_rdata_i[t];
      end
    end
  end

endmodule : l2_resp_route

//--- source/mempool_l2_pkg.sv
/*
 * Shared address map, widths, request structs and boot ROM image of the L2 system.
 * Every RTL file pulls this in by a wildcard import in its module header.
 */
package mempool_l2_pkg;

  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned NumInitiators  = 2;
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned NumCores       = 4;

  localparam int unsigned ByteOffWidth    = $clog2(StrbWidth);
  localparam int unsigned BankIdxWidth    = $clog2(NumL2Banks);
  localparam int unsigned BankWordWidth   = $clog2(L2BankNumWords);
  localparam int unsigned BootromNumWords = 16;
  localparam int unsigned BootromIdxWidth = $clog2(BootromNumWords);

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [StrbWidth-1:0]     strb_t;
  typedef logic [2:0]               tgt_idx_t;
  typedef logic [0:0]               ini_idx_t;
  typedef logic [BankWordWidth-1:0] word_addr_t;

  // Address map
  localparam int unsigned L2Size          = NumL2Banks * L2BankNumWords * StrbWidth;
  localparam addr_t       L2BaseAddr      = 32'h8000_0000;
  localparam addr_t       L2EndAddr       = L2BaseAddr + L2Size;
  localparam addr_t       BootromBaseAddr = 32'hA000_0000;
  localparam addr_t       BootromEndAddr  = BootromBaseAddr + BootromNumWords * StrbWidth;
  localparam addr_t       CtrlBaseAddr    = 32'h4000_0000;

  // Control block word indices (byte offsets 0 and 4)
  localparam word_addr_t CtrlWakeUpWord = 8'd0;
  localparam word_addr_t CtrlEocWord    = 8'd1;

  // Banks take indices 0 to NumL2Banks-1
  localparam int unsigned TgtBootrom = NumL2Banks;
  localparam int unsigned TgtCtrl    = NumL2Banks + 1;
  localparam int unsigned NumTargets = NumL2Banks + 2;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    word_addr_t addr;
    logic       we;
    data_t      wdata;
    strb_t      strb;
  } tgt_req_t;

  // Word-interleaved view of an L2 address
  typedef struct packed {
    logic [AddrWidth-ByteOffWidth-BankIdxWidth-BankWordWidth-1:0] upper;
    logic [BankWordWidth-1:0]                                     word;
    logic [BankIdxWidth-1:0]                                      bank;
    logic [ByteOffWidth-1:0]                                      offset;
  } l2_fields_t;

  typedef union packed {
    addr_t      raw;
    l2_fields_t l2;
  } l2_addr_u;

  // Boot code: cores park in wfi until woken, then jump to L2
  localparam data_t bootrom_image [BootromNumWords] = '{
    32'hf140_2573,  // csrr a0, mhartid
    32'h4000_02b7,  // lui t0, 0x40000
    32'h1050_0073,  // wfi
    32'h0002_a303,
    32'hfe03_0ce3,
    32'h8000_02b7,  // lui t0, 0x80000
    32'h0002_8067,  // jr t0
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_0013,
    32'h0000_006f,  // trap loop
    32'hb007_c0de
  };

endpackage : mempool_l2_pkg

//--- source/mempool_l2_system.sv
/*
 * Memory side of the cluster system: L2 banks, boot ROM and control block.
 * Port 0 is the cluster, port 1 the host; both use a req/gnt/rvalid handshake.
 */
`timescale 1ns/1ns

module mempool_l2_system
  import mempool_l2_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic     [NumInitiators-1:0] req_i,
  input  mem_req_t [NumInitiators-1:0] mem_req_i,
  output logic     [NumInitiators-1:0] gnt_o,
  output logic     [NumInitiators-1:0] rvalid_o,
  output data_t    [NumInitiators-1:0] rdata_o,
  output logic     [NumCores-1:0]      wake_up_o,
  output data_t                        eoc_o,
  output logic                         eoc_valid_o
);

  tgt_idx_t [NumInitiators-1:0] ini_tgt_idx;
  tgt_req_t [NumInitiators-1:0] ini_tgt_req;
  logic     [NumTargets-1:0]    tgt_valid;
  tgt_req_t [NumTargets-1:0]    tgt_req;
  ini_idx_t [NumTargets-1:0]    tgt_ini;
  data_t    [NumTargets-1:0]    tgt_rdata;

  l2_region_decode u_l2_region_decode (
    .req_i     (req_i      ),
    .mem_req_i (mem_req_i  ),
    .tgt_idx_o (ini_tgt_idx),
    .tgt_req_o (ini_tgt_req)
  );

  l2_bank_xbar u_l2_bank_xbar (
    .clk_i       (clk_i      ),
    .reset_i     (reset_i    ),
    .req_i       (req_i      ),
    .tgt_idx_i   (ini_tgt_idx),
    .tgt_req_i   (ini_tgt_req),
    .gnt_o       (gnt_o      ),
    .tgt_valid_o (tgt_valid  ),
    .tgt_req_o   (tgt_req    ),
    .tgt_ini_o   (tgt_ini    )
  );

  l2_bank_array u_l2_bank_array (
    .clk_i        (clk_i                       ),
    .bank_valid_i (tgt_valid[NumL2Banks-1:0]   ),
    .bank_req_i   (tgt_req[NumL2Banks-1:0]     ),
    .bank_rdata_o (tgt_rdata[NumL2Banks-1:0]   )
  );

  bootrom u_bootrom (
    .clk_i   (clk_i                    ),
    .req_i   (tgt_valid[TgtBootrom]    ),
    .addr_i  (tgt_req[TgtBootrom].addr ),
    .rdata_o (tgt_rdata[TgtBootrom]    )
  );

  ctrl_registers u_ctrl_registers (
    .clk_i       (clk_i             ),
    .reset_i     (reset_i           ),
    .valid_i     (tgt_valid[TgtCtrl]),
    .req_i       (tgt_req[TgtCtrl]  ),
    .rdata_o     (tgt_rdata[TgtCtrl]),
    .wake_up_o   (wake_up_o         ),
    .eoc_o       (eoc_o             ),
    .eoc_valid_o (eoc_valid_o       )
  );

  l2_resp_route u_l2_resp_route (
    .clk_i       (clk_i    ),
    .reset_i     (reset_i  ),
    .tgt_valid_i (tgt_valid),
    .tgt_ini_i   (tgt_ini  ),
    .tgt_rdata_i (tgt_rdata),
    .rvalid_o    (rvalid_o ),
    .rdata_o     (rdata_o  )
  );

endmodule : mempool_l2_system
